//--- Makefile
# Verilator build and run for the peripheral bus testbench

VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
logic/periph_pkg.sv
logic/periph_addr_decode.sv
logic/periph_read_hold.sv
logic/gpio_block.sv
logic/byte_reg_periph.sv
logic/periph_top.sv
verification/periph_tb.sv

//--- logic/byte_reg_periph.sv
// Simple byte peripheral
// Four read/write byte registers, register 0 drives the output byte

`default_nettype none

module byte_reg_periph
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_we,
    input  logic [3:0]        i_addr,
    input  logic [byte_w-1:0] i_wdata,
    output logic [byte_w-1:0] o_rdata,
    output logic [byte_w-1:0] o_uo_out
);

    logic [byte_regs-1:0][byte_w-1:0] regs;
    logic                             hit;

    // Only the low four addresses map to registers
    assign hit = (i_addr[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (i_we && hit) begin
            regs[i_addr[1:0]] <= i_wdata;
        end
    end

    assign o_rdata  = hit ? regs[i_addr[1:0]] : '0;
    assign o_uo_out = regs[0];

endmodule

`default_nettype wire

//--- logic/gpio_block.sv
// GPIO peripheral
// Output register, input pin read-back, per-pin function selects
// Output pin routing from user and simple slots

`default_nettype none

module gpio_block
    import periph_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               i_we,
    input  logic [5:0]                         i_offset,
    input  logic [byte_w-1:0]                  i_wdata,
    input  logic [pin_count-1:0]               i_ui_in,
    input  logic [simple_used-1:0][byte_w-1:0] i_byte_out,
    output logic [data_w-1:0]                  o_rdata,
    output logic [pin_count-1:0]               o_uo_out
);

    logic [pin_count-1:0]                 out_reg;
    logic [pin_count-1:0][func_sel_w-1:0] func_sel;
    logic                                 func_hit;
    logic [$clog2(pin_count)-1:0]         func_idx;

    // Select words sit from the base offset to the end of the slot
    assign func_hit = (i_offset >= gpio_func_base) && (i_offset[1:0] == 2'b00);
    assign func_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_reg <= '0;
        end else if (i_we && (i_offset == gpio_out_off)) begin
            out_reg <= i_wdata;
        end
    end

    // All pins start out driven by the GPIO output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            func_sel <= {pin_count{{1'b0, slot_gpio}}};
        end else if (i_we && func_hit) begin
            func_sel[func_idx] <= i_wdata[func_sel_w-1:0];
        end
    end

    always_comb begin
        if (i_offset == gpio_out_off) begin
            o_rdata = data_w'(out_reg);
        end else if (i_offset == gpio_in_off) begin
            o_rdata = data_w'(i_ui_in);
        end else if (func_hit) begin
            o_rdata = data_w'(func_sel[func_idx]);
        end else begin
            o_rdata = '0;
        end
    end

    // Each pin takes its own bit from the chosen slot's output byte
    always_comb begin
        for (int p = 0; p < pin_count; p++) begin
            o_uo_out[p] = 1'b0;
            if (func_sel[p][func_sel_w-1]) begin
                for (int k = 0; k < simple_used; k++) begin
                    if (func_sel[p][3:0] == 4'(k)) begin
                        o_uo_out[p] = i_byte_out[k][p];
                    end
                end
            end else if (func_sel[p][3:0] == slot_gpio) begin
                o_uo_out[p] = out_reg[p];
            end
            // other slots have no outputs, pin stays low
        end
    end

endmodule

`default_nettype wire

//--- logic/periph_addr_decode.sv
// Address decode for the peripheral bus
// Slot selects, write strobes, read data and ready mux

`default_nettype none

module periph_addr_decode
    import periph_pkg::*;
(
    input  periph_req_t                        i_req,
    input  logic [data_w-1:0]                  i_gpio_rdata,
    input  logic [simple_used-1:0][byte_w-1:0] i_byte_rdata,
    output logic                               o_gpio_we,
    output logic [simple_used-1:0]             o_byte_we,
    output slot_sel_t                          o_sel,
    output logic [data_w-1:0]                  o_peri_rdata,
    output logic                               o_peri_ready
);

    logic       is_simple;
    logic [3:0] simple_idx;
    logic [3:0] user_idx;

    // Top address bit splits user and simple regions
    assign is_simple  = i_req.addr[addr_w-1];
    assign simple_idx = i_req.addr[7:4];
    assign user_idx   = i_req.addr[9:6];

    always_comb begin
        o_sel.user   = '0;
        o_sel.simple = '0;
        o_sel.write  = (i_req.write_n != size_none);
        if (is_simple) begin
            o_sel.simple[simple_idx] = 1'b1;
        end else begin
            o_sel.user[user_idx] = 1'b1;
        end
    end

    assign o_gpio_we = o_sel.write && o_sel.user[slot_gpio];
    assign o_byte_we = o_sel.simple[simple_used-1:0] & {simple_used{o_sel.write}};

    // Unpopulated slots read as zero
    always_comb begin
        o_peri_rdata = '0;
        if (is_simple) begin
            for (int k = 0; k < simple_used; k++) begin
                if (simple_idx == 4'(k)) begin
                    o_peri_rdata = data_w'(i_byte_rdata[k]);
                end
            end
        end else if (user_idx == slot_gpio) begin
            o_peri_rdata = i_gpio_rdata;
        end
    end

    // Every slot answers in the same cycle
    assign o_peri_ready = 1'b1;

endmodule

`default_nettype wire

//--- logic/periph_pkg.sv
// Shared definitions for the peripheral bus
// Bus widths, size codes, GPIO register map, slot numbers
// Core request and decoded slot select structs

`default_nettype none

package periph_pkg;

    // Bus widths
    localparam int addr_w      = 11;
    localparam int data_w      = 32;
    localparam int byte_w      = 8;
    localparam int pin_count   = 8;
    localparam int slot_count  = 16;

    // Access size codes: 00 byte, 01 half, 10 word, 11 no access
    localparam logic [1:0] size_none = 2'b11;

    // User slot holding the GPIO block
    localparam logic [3:0] slot_gpio = 4'd1;

    // Pin function select, top bit picks a simple slot
    localparam int func_sel_w = 5;

    // GPIO register offsets within its 64-byte slot
    localparam logic [5:0] gpio_out_off   = 6'd0;
    localparam logic [5:0] gpio_in_off    = 6'd4;
    localparam logic [5:0] gpio_func_base = 6'd32;

    // Byte register peripherals
    localparam int byte_regs   = 4;
    localparam int simple_used = 2;

    // One request from the core
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [1:0]        write_n;
        logic [1:0]        read_n;
    } periph_req_t;

    // Decoded slot, one-hot per address region
    typedef struct packed {
        logic [slot_count-1:0] user;
        logic [slot_count-1:0] simple;
        logic                  write;
    } slot_sel_t;

endpackage

`default_nettype wire

//--- logic/periph_read_hold.sv
// Read response holder
// Captures read data once per read and holds it until read complete
// Registered read ready, write acknowledge passed straight through

`default_nettype none

module periph_read_hold
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        i_read_n,
    input  logic [1:0]        i_write_n,
    input  logic [data_w-1:0] i_peri_rdata,
    input  logic              i_peri_ready,
    input  logic              i_data_read_complete,
    output logic [data_w-1:0] o_data_out,
    output logic              o_data_ready
);

    typedef enum logic {
        st_idle,
        st_hold
    } hold_state_t;

    hold_state_t       state;
    logic [data_w-1:0] data_r;
    logic              ready_r;
    logic              read_req;
    logic              capture;

    assign read_req = (i_read_n != size_none);
    assign capture  = (state == st_idle) && read_req && i_peri_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            ready_r <= 1'b0;
        end else begin
            // Ready lags the read by one cycle since the data is registered
            ready_r <= read_req && i_peri_ready;
            case (state)
                st_idle: begin
                    if (capture) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (i_data_read_complete) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_peri_rdata;
        end
    end

    assign o_data_out   = data_r;
    assign o_data_ready = ready_r || (i_write_n != size_none);

endmodule

`default_nettype wire

//--- logic/periph_top.sv
// Peripheral bus top level
// Address decode, read holder, GPIO and two byte peripherals

`default_nettype none

module periph_top
    import periph_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_req_t          i_req,
    input  logic [pin_count-1:0] i_ui_in,
    input  logic                 i_data_read_complete,
    output logic [data_w-1:0]    o_data_out,
    output logic                 o_data_ready,
    output logic [pin_count-1:0] o_uo_out
);

    logic                               gpio_we;
    logic [simple_used-1:0]             byte_we;
    logic [data_w-1:0]                  gpio_rdata;
    logic [simple_used-1:0][byte_w-1:0] byte_rdata;
    logic [simple_used-1:0][byte_w-1:0] byte_out;
    logic [data_w-1:0]                  peri_rdata;
    logic                               peri_ready;

    periph_addr_decode u_decode (
        .i_req        (i_req),
        .i_gpio_rdata (gpio_rdata),
        .i_byte_rdata (byte_rdata),
        .o_gpio_we    (gpio_we),
        .o_byte_we    (byte_we),
        .o_sel        (),
        .o_peri_rdata (peri_rdata),
        .o_peri_ready (peri_ready)
    );

    periph_read_hold u_hold (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_read_n             (i_req.read_n),
        .i_write_n            (i_req.write_n),
        .i_peri_rdata         (peri_rdata),
        .i_peri_ready         (peri_ready),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    gpio_block u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_we       (gpio_we),
        .i_offset   (i_req.addr[5:0]),
        .i_wdata    (i_req.wdata[byte_w-1:0]),
        .i_ui_in    (i_ui_in),
        .i_byte_out (byte_out),
        .o_rdata    (gpio_rdata),
        .o_uo_out   (o_uo_out)
    );

    // Simple slots 0 and 1
    for (genvar k = 0; k < simple_used; k++) begin : g_byte
        byte_reg_periph u_byte (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_we     (byte_we[k]),
            .i_addr   (i_req.addr[3:0]),
            .i_wdata  (i_req.wdata[byte_w-1:0]),
            .o_rdata  (byte_rdata[k]),
            .o_uo_out (byte_out[k])
        );
    end

endmodule

`default_nettype wire

//--- verification/periph_tb.sv
// Testbench for the peripheral bus top level
// Stimulus table of reads and writes with expected data and pin outputs
// Clock, reset, table loop, checks, cycle limit and summary

`default_nettype none

module periph_tb
    import periph_pkg::*;
;

    typedef enum logic [1:0] {
        kind_read,
        kind_write,
        kind_hold
    } access_kind_t;

    localparam int n_rows      = 36;
    localparam int cycle_limit = n_rows * 8 + 20;

    logic                 clk;
    logic                 rst_n;
    periph_req_t          i_req;
    logic [pin_count-1:0] i_ui_in;
    logic                 i_data_read_complete;
    logic [data_w-1:0]    o_data_out;
    logic                 o_data_ready;
    logic [pin_count-1:0] o_uo_out;

    // Stimulus table, one entry per access
    string             row_name  [n_rows];
    access_kind_t      row_kind  [n_rows];
    logic [addr_w-1:0] row_addr  [n_rows];
    logic [data_w-1:0] row_wdata [n_rows];
    logic [7:0]        row_ui    [n_rows];
    logic [data_w-1:0] row_rdata [n_rows];
    logic [7:0]        row_uo    [n_rows];
    int                row_count;

    logic [7:0] cur_ui;
    int         cycles;
    int         err_value;
    int         err_ready;
    int         err_other;

    periph_top UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_req                (i_req),
        .i_ui_in              (i_ui_in),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Error: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [addr_w-1:0] user_addr(input logic [3:0] slot,
                                                   input logic [5:0] offset);
        return {1'b0, slot, offset};
    endfunction

    function automatic logic [addr_w-1:0] simple_addr(input logic [3:0] slot,
                                                     input logic [3:0] idx);
        return {1'b1, 2'b00, slot, idx};
    endfunction

    function automatic periph_req_t idle_req();
        periph_req_t req;
        req.addr    = '0;
        req.wdata   = '0;
        req.write_n = size_none;
        req.read_n  = size_none;
        return req;
    endfunction

    // Word-size access of the given kind
    function automatic periph_req_t make_req(input access_kind_t kind,
                                             input logic [addr_w-1:0] addr,
                                             input logic [data_w-1:0] wdata);
        periph_req_t req;
        req       = idle_req();
        req.addr  = addr;
        req.wdata = wdata;
        if (kind == kind_write) begin
            req.write_n = 2'b10;
        end else begin
            req.read_n = 2'b10;
        end
        return req;
    endfunction

    task automatic add_row(input string name, input access_kind_t kind,
                           input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                           input logic [data_w-1:0] rdata, input logic [7:0] uo);
        if (row_count < n_rows) begin
            row_name[row_count]  = name;
            row_kind[row_count]  = kind;
            row_addr[row_count]  = addr;
            row_wdata[row_count] = wdata;
            row_ui[row_count]    = cur_ui;
            row_rdata[row_count] = rdata;
            row_uo[row_count]    = uo;
        end
        row_count++;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", name, what, expected, actual);
            err_value++;
        end
    endtask

    task automatic check_ready(input string name, input logic expected);
        assert (o_data_ready === expected) else begin
            $display("Error: %s ready expected %0d actual %0d", name, expected, o_data_ready);
            err_ready++;
        end
    endtask

    // Expected values follow the register map and pin routing rules
    task automatic build_table();
        logic [7:0] g1;
        logic [7:0] g2;
        logic [7:0] uo_now;
        logic [7:0] bv [0:1][0:3];
        uo_now = 8'h00;
        cur_ui = 8'($urandom);
        for (int p = 0; p < pin_count; p++) begin
            add_row($sformatf("reset_sel%0d", p), kind_read,
                    user_addr(slot_gpio, gpio_func_base + 6'(4 * p)), '0, 32'(slot_gpio), uo_now);
        end
        g1     = 8'($urandom);
        uo_now = g1;
        add_row("gpio_write", kind_write, user_addr(slot_gpio, gpio_out_off),
                32'(g1), '0, uo_now);
        add_row("gpio_out_read", kind_read, user_addr(slot_gpio, gpio_out_off),
                '0, 32'(g1), uo_now);
        cur_ui = 8'($urandom);
        add_row("gpio_in_read", kind_read, user_addr(slot_gpio, gpio_in_off),
                '0, 32'(cur_ui), uo_now);
        for (int s = 0; s < simple_used; s++) begin
            for (int r = 0; r < byte_regs; r++) begin
                bv[s][r] = 8'($urandom);
                add_row($sformatf("byte_write_s%0d_r%0d", s, r), kind_write,
                        simple_addr(4'(s), 4'(r)), 32'(bv[s][r]), '0, uo_now);
            end
        end
        for (int s = 0; s < simple_used; s++) begin
            for (int r = 0; r < byte_regs; r++) begin
                add_row($sformatf("byte_read_s%0d_r%0d", s, r), kind_read,
                        simple_addr(4'(s), 4'(r)), '0, 32'(bv[s][r]), uo_now);
            end
        end
        // Pin 3 moves to simple slot 1
        uo_now = (g1 & ~8'h08) | (bv[1][0] & 8'h08);
        add_row("pin3_sel_write", kind_write, user_addr(slot_gpio, gpio_func_base + 6'd12),
                32'd17, '0, uo_now);
        add_row("pin3_sel_read", kind_read, user_addr(slot_gpio, gpio_func_base + 6'd12),
                '0, 32'd17, uo_now);
        add_row("unused_user5", kind_read, user_addr(4'd5, 6'd0), '0, '0, uo_now);
        add_row("unused_simple9", kind_read, simple_addr(4'd9, 4'd0), '0, '0, uo_now);
        add_row("unused_gpio_off8", kind_read, user_addr(slot_gpio, 6'd8), '0, '0, uo_now);
        g2 = g1 ^ 8'($urandom_range(255, 1));
        add_row("hold_first_read", kind_hold, user_addr(slot_gpio, gpio_out_off),
                '0, 32'(g1), uo_now);
        uo_now = (g2 & ~8'h08) | (bv[1][0] & 8'h08);
        add_row("hold_write", kind_write, user_addr(slot_gpio, gpio_out_off),
                32'(g2), '0, uo_now);
        add_row("hold_repeat_read", kind_read, user_addr(slot_gpio, gpio_out_off),
                '0, 32'(g1), uo_now);
        add_row("hold_new_read", kind_read, user_addr(slot_gpio, gpio_out_off),
                '0, 32'(g2), uo_now);
    endtask

    task automatic apply_row(input int i);
        @(posedge clk);
        i_req   <= make_req(row_kind[i], row_addr[i], row_wdata[i]);
        i_ui_in <= row_ui[i];
        if (row_kind[i] == kind_write) begin
            // Write acknowledge in the same cycle
            @(negedge clk);
            check_ready(row_name[i], 1'b1);
            @(posedge clk);
            i_req <= idle_req();
            @(negedge clk);
            check_value(row_name[i], "uo_out", 32'(row_uo[i]), 32'(o_uo_out));
        end else begin
            @(negedge clk);
            check_ready(row_name[i], 1'b0);
            @(negedge clk);
            check_ready(row_name[i], 1'b1);
            check_value(row_name[i], "data", row_rdata[i], o_data_out);
            check_value(row_name[i], "uo_out", 32'(row_uo[i]), 32'(o_uo_out));
            @(posedge clk);
            if (row_kind[i] == kind_hold) begin
                // Request stays on with no completion, ready stays up
                @(negedge clk);
                check_ready(row_name[i], 1'b1);
                @(posedge clk);
                i_req <= idle_req();
            end else begin
                i_req                <= idle_req();
                i_data_read_complete <= 1'b1;
                @(posedge clk);
                i_data_read_complete <= 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hbca4_c752));
        rst_n                = 1'b0;
        i_req                = idle_req();
        i_ui_in              = '0;
        i_data_read_complete = 1'b0;
        cycles               = 0;
        err_value            = 0;
        err_ready            = 0;
        err_other            = 0;
        row_count            = 0;
        build_table();
        assert (row_count == n_rows) else begin
            $display("Error: stimulus table holds %0d rows instead of %0d", row_count, n_rows);
            err_other++;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ready("after_reset", 1'b0);
        check_value("after_reset", "uo_out", 32'h0, 32'(o_uo_out));
        for (int i = 0; i < row_count && i < n_rows; i++) begin
            apply_row(i);
        end
        $display("Summary: %0d rows, %0d value errors, %0d ready errors, %0d other errors",
                 row_count, err_value, err_ready, err_other);
        if (err_value + err_ready + err_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
